//--- common/scan_cfg.svh
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

// Number of per-stream context slots in each lane
`define SCAN_STREAMS 64

// Width of one payload byte
`define SCAN_BYTE_W 8

// Width of the lane hit counters and the alert counter
`define SCAN_CNT_W 16

`endif

//--- common/scan_pkg.sv
package scan_pkg;

   `include "scan_cfg.svh"

   // Stream identifier, sized from the context count
   typedef logic [$clog2(`SCAN_STREAMS)-1:0] stream_id_t;

   // Keyword automaton state
   // Number of leading bytes of "GET" seen so far (0 to 2)
   typedef logic [1:0] keyword_ctx_t;

   // Line automaton state, set when the last byte was a CR
   typedef logic crlf_ctx_t;

   // Pattern bytes of the keyword "GET"
   localparam logic [`SCAN_BYTE_W-1:0] KW_BYTE0 = 8'h47;
   localparam logic [`SCAN_BYTE_W-1:0] KW_BYTE1 = 8'h45;
   localparam logic [`SCAN_BYTE_W-1:0] KW_BYTE2 = 8'h54;

   // Carriage return and line feed
   localparam logic [`SCAN_BYTE_W-1:0] CR_BYTE = 8'h0D;
   localparam logic [`SCAN_BYTE_W-1:0] LF_BYTE = 8'h0A;

   // Automaton selection for a matcher lane
   localparam int PATTERN_KEYWORD = 0;
   localparam int PATTERN_CRLF    = 1;

   // Per-packet result of one lane
   typedef struct packed {
      // Pattern seen in this packet while the lane was enabled
      logic hit;
   } lane_report_t;

endpackage

//--- common/scan_if.sv
`timescale 1ns/1ps

`include "scan_cfg.svh"

// Byte stream shared by both matcher lanes
interface scan_if;
   logic [`SCAN_BYTE_W-1:0] byte_in;
   logic                    char_vld;
   logic                    load_state;
   logic                    new_stream;
   scan_pkg::stream_id_t    stream_id;
   logic                    eop;

   modport src  (output byte_in, char_vld, load_state, new_stream, stream_id, eop);
   modport sink (input  byte_in, char_vld, load_state, new_stream, stream_id, eop);
endinterface

// Per-packet result of one lane towards the combiner
interface report_if;
   logic                   report_vld;
   scan_pkg::lane_report_t report;
   logic [`SCAN_CNT_W-1:0] lane_count;
   logic                   lane_enabled;

   modport lane  (output report_vld, report, lane_count, lane_enabled);
   modport merge (input  report_vld, report, lane_count, lane_enabled);
endinterface

//--- matcher/stream_ctx_store.sv
`timescale 1ns/1ps

`include "scan_cfg.svh"

module stream_ctx_store #(
   parameter type ctx_t = scan_pkg::keyword_ctx_t
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 load_state,
   input  logic                 new_stream,
   input  scan_pkg::stream_id_t stream_id,
   input  bit                   save,
   input  ctx_t                 save_ctx,
   output ctx_t                 ctx,
   output logic                 ctx_vld
);

   // One saved automaton state per stream
   ctx_t mem [`SCAN_STREAMS];

   // Stream of the packet in progress, used for the save at eop
   scan_pkg::stream_id_t cur_id;

   // Restore strobe towards the automaton
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         ctx_vld <= 1'b0;
      else
         ctx_vld <= load_state;
   end

   // Context fetch at packet start
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         cur_id <= stream_id;
         // Unknown stream starts from the idle state
         if (new_stream)
            ctx <= '0;
         else
            ctx <= mem[stream_id];
      end
   end

   // Write back at packet end, only for an enabled lane
   always_ff @(posedge clk)
   begin
      if (save)
         mem[cur_id] <= save_ctx;
   end

endmodule

//--- matcher/dfa_keyword.sv
`timescale 1ns/1ps

`include "scan_cfg.svh"

module dfa_keyword (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`SCAN_BYTE_W-1:0] byte_in,
   input  logic                    char_vld,
   input  scan_pkg::keyword_ctx_t  ctx_in,
   input  logic                    ctx_vld,
   output scan_pkg::keyword_ctx_t  state,
   output logic                    accept
);
   import scan_pkg::*;

   keyword_ctx_t state_q;
   keyword_ctx_t next_state;

   // A restored context takes effect in the same cycle as a first byte
   assign state = ctx_vld ? ctx_in : state_q;

   always_comb
   begin
      next_state = 2'd0;
      accept     = 1'b0;
      case (state)
         2'd0:
            if (byte_in == KW_BYTE0)
               next_state = 2'd1;
         2'd1:
            if (byte_in == KW_BYTE1)
               next_state = 2'd2;
            else if (byte_in == KW_BYTE0)
               next_state = 2'd1;
         2'd2:
            if (byte_in == KW_BYTE2)
            begin
               // Full match, restart so matches never overlap
               next_state = 2'd0;
               accept     = char_vld;
            end
            else if (byte_in == KW_BYTE0)
               next_state = 2'd1;
         default:
            next_state = 2'd0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_q <= 2'd0;
      else if (char_vld)
         state_q <= next_state;
      else if (ctx_vld)
         state_q <= ctx_in;
   end

endmodule

//--- matcher/dfa_crlf.sv
`timescale 1ns/1ps

`include "scan_cfg.svh"

module dfa_crlf (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`SCAN_BYTE_W-1:0] byte_in,
   input  logic                    char_vld,
   input  scan_pkg::crlf_ctx_t     ctx_in,
   input  logic                    ctx_vld,
   output scan_pkg::crlf_ctx_t     state,
   output logic                    accept
);
   import scan_pkg::*;

   crlf_ctx_t state_q;

   // Restored context overrides the register for this cycle
   assign state = ctx_vld ? ctx_in : state_q;

   // LF right after CR completes the pair
   assign accept = char_vld && state && (byte_in == LF_BYTE);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_q <= 1'b0;
      else if (char_vld)
         // Any byte other than CR clears, an LF match included
         state_q <= (byte_in == CR_BYTE);
      else if (ctx_vld)
         state_q <= ctx_in;
   end

endmodule

//--- matcher/stream_matcher.sv
`timescale 1ns/1ps

`include "scan_cfg.svh"

module stream_matcher #(
   parameter type ctx_t   = scan_pkg::keyword_ctx_t,
   parameter int  PATTERN = scan_pkg::PATTERN_KEYWORD
) (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   enable,
   scan_if.sink   src,
   report_if.lane rpt
);
   import scan_pkg::*;

   ctx_t                   ctx;
   logic                   ctx_vld;
   ctx_t                   state;
   logic                   accept;
   logic                   hit_flag;
   logic                   hit_gated;
   logic [`SCAN_CNT_W-1:0] count;
   lane_report_t           report_d;

   // Per-stream state, saved at eop only when this lane is enabled
   stream_ctx_store #(.ctx_t(ctx_t)) ctx_store_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (src.load_state),
      .new_stream (src.new_stream),
      .stream_id  (src.stream_id),
      .save       (src.eop && enable),
      .save_ctx   (state),
      .ctx        (ctx),
      .ctx_vld    (ctx_vld)
   );

   // Automaton chosen by lane type
   if (PATTERN == PATTERN_KEYWORD)
   begin : g_keyword
      dfa_keyword dfa_i (
         .clk      (clk),
         .rst_n    (rst_n),
         .byte_in  (src.byte_in),
         .char_vld (src.char_vld),
         .ctx_in   (ctx),
         .ctx_vld  (ctx_vld),
         .state    (state),
         .accept   (accept)
      );
   end
   else
   begin : g_crlf
      dfa_crlf dfa_i (
         .clk      (clk),
         .rst_n    (rst_n),
         .byte_in  (src.byte_in),
         .char_vld (src.char_vld),
         .ctx_in   (ctx),
         .ctx_vld  (ctx_vld),
         .state    (state),
         .accept   (accept)
      );
   end

   // A hit only counts for an enabled lane
   assign hit_gated = hit_flag && enable;
   assign report_d  = '{hit: hit_gated};

   // Hit flag, counter and report strobe
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         hit_flag       <= 1'b0;
         count          <= '0;
         rpt.report_vld <= 1'b0;
      end
      else
      begin
         rpt.report_vld <= src.eop;
         // New packet starts without a hit
         if (src.load_state)
            hit_flag <= 1'b0;
         if (accept)
            hit_flag <= 1'b1;
         if (src.eop)
         begin
            count <= count + {{(`SCAN_CNT_W-1){1'b0}}, hit_gated};
            // Disabled lane drops what it saw in this packet
            if (!enable)
               hit_flag <= 1'b0;
         end
      end
   end

   // Report payload, sampled at eop
   always_ff @(posedge clk)
   begin
      if (src.eop)
      begin
         rpt.report       <= report_d;
         rpt.lane_enabled <= enable;
      end
   end

   assign rpt.lane_count = count;

endmodule

//--- verilog/scan_combiner.sv
`timescale 1ns/1ps

`include "scan_cfg.svh"

module scan_combiner (
   input  logic                   clk,
   input  logic                   rst_n,
   report_if.merge                kw,
   report_if.merge                crlf,
   output logic                   verdict_vld,
   output logic                   hit_keyword,
   output logic                   hit_crlf,
   output logic                   alert,
   output logic [`SCAN_CNT_W-1:0] alert_count,
   output logic [`SCAN_CNT_W-1:0] count_keyword,
   output logic [`SCAN_CNT_W-1:0] count_crlf
);

   logic kw_hit;
   logic crlf_hit;
   logic both_hit;

   // Lane hits, qualified by the report strobe and lane enable
   assign kw_hit   = kw.report_vld && kw.lane_enabled && kw.report.hit;
   assign crlf_hit = crlf.report_vld && crlf.lane_enabled && crlf.report.hit;
   assign both_hit = kw_hit && crlf_hit;

   // Verdict lands one cycle after the lane reports
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         verdict_vld <= 1'b0;
         hit_keyword <= 1'b0;
         hit_crlf    <= 1'b0;
         alert       <= 1'b0;
         alert_count <= '0;
      end
      else
      begin
         // Both lanes see the same eop, so their strobes coincide
         verdict_vld <= kw.report_vld || crlf.report_vld;
         hit_keyword <= kw_hit;
         hit_crlf    <= crlf_hit;
         alert       <= both_hit;
         if (both_hit)
            alert_count <= alert_count + 1'b1;
      end
   end

   // Lane counters go straight to the top level
   assign count_keyword = kw.lane_count;
   assign count_crlf    = crlf.lane_count;

endmodule

//--- verilog/stream_scan_top.sv
`timescale 1ns/1ps

`include "scan_cfg.svh"

module stream_scan_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`SCAN_BYTE_W-1:0] byte_in,
   input  logic                    char_vld,
   input  logic                    load_state,
   input  logic                    new_stream,
   input  scan_pkg::stream_id_t    stream_id,
   input  logic                    eop,
   input  logic                    enable_keyword,
   input  logic                    enable_crlf,
   output logic                    verdict_vld,
   output logic                    hit_keyword,
   output logic                    hit_crlf,
   output logic                    alert,
   output logic [`SCAN_CNT_W-1:0]  count_keyword,
   output logic [`SCAN_CNT_W-1:0]  count_crlf,
   output logic [`SCAN_CNT_W-1:0]  alert_count
);
   import scan_pkg::*;

   // Byte stream shared by both lanes
   scan_if   bus ();
   // One report channel per lane
   report_if kw_rpt ();
   report_if crlf_rpt ();

   assign bus.byte_in    = byte_in;
   assign bus.char_vld   = char_vld;
   assign bus.load_state = load_state;
   assign bus.new_stream = new_stream;
   assign bus.stream_id  = stream_id;
   assign bus.eop        = eop;

   // Keyword lane for "GET"
   stream_matcher #(
      .ctx_t   (keyword_ctx_t),
      .PATTERN (PATTERN_KEYWORD)
   ) keyword_lane_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .enable (enable_keyword),
      .src    (bus.sink),
      .rpt    (kw_rpt.lane)
   );

   // Line lane for CR LF
   stream_matcher #(
      .ctx_t   (crlf_ctx_t),
      .PATTERN (PATTERN_CRLF)
   ) crlf_lane_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .enable (enable_crlf),
      .src    (bus.sink),
      .rpt    (crlf_rpt.lane)
   );

   scan_combiner scan_combiner_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .kw            (kw_rpt.merge),
      .crlf          (crlf_rpt.merge),
      .verdict_vld   (verdict_vld),
      .hit_keyword   (hit_keyword),
      .hit_crlf      (hit_crlf),
      .alert         (alert),
      .alert_count   (alert_count),
      .count_keyword (count_keyword),
      .count_crlf    (count_crlf)
   );

endmodule

//--- test/stream_scan_chk.sv
`timescale 1ns/1ps

`include "scan_cfg.svh"

module stream_scan_chk (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   enable_keyword,
   input logic                   enable_crlf,
   input logic                   verdict_vld,
   input logic                   hit_keyword,
   input logic                   hit_crlf,
   input logic                   alert,
   input logic [`SCAN_CNT_W-1:0] alert_count
);

   // Number of failed assertions, read back by the testbench
   int fail_count = 0;

   task automatic note_failure(input string what);
      $error("%s", what);
      fail_count++;
   endtask

   // Verdict is a one-cycle pulse
   verdict_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      verdict_vld |=> !verdict_vld)
      else note_failure("verdict_vld held for more than one cycle");

   // Alert only when both lanes hit
   // Both lanes were enabled at the eop two edges back
   alert_both: assert property (@(posedge clk) disable iff (!rst_n)
      alert |-> (hit_keyword && hit_crlf &&
                 $past(enable_keyword, 2) && $past(enable_crlf, 2)))
      else note_failure("alert without both lane hits");

   // Alert counter only moves up outside reset
   count_up: assert property (@(posedge clk) disable iff (!rst_n)
      alert_count >= $past(alert_count))
      else note_failure("alert_count decreased");

   // Reset edge leaves verdict and alert low
   reset_quiet: assert property (@(posedge clk)
      !rst_n |=> (!verdict_vld && !alert))
      else note_failure("output pulse during reset");

endmodule

bind stream_scan_top stream_scan_chk chk_i (
   .clk            (clk),
   .rst_n          (rst_n),
   .enable_keyword (enable_keyword),
   .enable_crlf    (enable_crlf),
   .verdict_vld    (verdict_vld),
   .hit_keyword    (hit_keyword),
   .hit_crlf       (hit_crlf),
   .alert          (alert),
   .alert_count    (alert_count)
);

//--- test/stream_scan_tb.sv
`timescale 1ns/1ps

`include "scan_cfg.svh"

module stream_scan_tb;
   import scan_pkg::*;

   typedef logic [`SCAN_BYTE_W-1:0] byte_t;
   typedef logic [`SCAN_CNT_W-1:0]  count_t;

   // Pattern characters as the model sees them
   localparam byte_t CH_G  = "G";
   localparam byte_t CH_E  = "E";
   localparam byte_t CH_T  = "T";
   localparam byte_t CH_CR = 8'h0d;
   localparam byte_t CH_LF = 8'h0a;
   localparam int    VERDICT_TIMEOUT = 20;

   logic       clk;
   logic       rst_n;
   byte_t      byte_in;
   logic       char_vld;
   logic       load_state;
   logic       new_stream;
   stream_id_t stream_id;
   logic       eop;
   logic       enable_keyword;
   logic       enable_crlf;
   logic       verdict_vld;
   logic       hit_keyword;
   logic       hit_crlf;
   logic       alert;
   count_t     count_keyword;
   count_t     count_crlf;
   count_t     alert_count;

   // Reference model, one state per stream and lane
   keyword_ctx_t kw_mem [`SCAN_STREAMS];
   crlf_ctx_t    crlf_mem [`SCAN_STREAMS];
   bit           kw_saved [`SCAN_STREAMS];
   bit           crlf_saved [`SCAN_STREAMS];
   count_t       exp_count_kw;
   count_t       exp_count_crlf;
   count_t       exp_alert_count;

   // Payload of the next packet
   byte_t  pkt [$];
   integer seed;
   int     errors;
   int     checks;
   bit     aborted;

   stream_scan_top stream_scan_top_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[FAIL] %0d ns %s expected %0b got %0b", $time, name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input count_t exp, input count_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[FAIL] %0d ns %s expected %0d got %0d", $time, name, exp, act);
      end
   endtask

   task automatic load_text(input string s);
      pkt.delete();
      for (int i = 0; i < s.len(); i++)
         pkt.push_back(byte_t'(s[i]));
   endtask

   // Applies the matching rules to pkt and updates the stored states
   task automatic model_packet(input stream_id_t sid, input bit new_s, input bit ekw,
                               input bit ecrlf, output bit hk, output bit hc);
      keyword_ctx_t ks;
      crlf_ctx_t    cs;
      hk = 1'b0;
      hc = 1'b0;
      ks = new_s ? 2'd0 : kw_mem[sid];
      cs = new_s ? 1'b0 : crlf_mem[sid];
      foreach (pkt[i])
      begin
         // Full match restarts at zero, a stray G restarts at one
         if (ks == 2'd2 && pkt[i] == CH_T)
         begin
            hk = 1'b1;
            ks = 2'd0;
         end
         else if (ks == 2'd1 && pkt[i] == CH_E)
            ks = 2'd2;
         else if (pkt[i] == CH_G)
            ks = 2'd1;
         else
            ks = 2'd0;
         if (cs && pkt[i] == CH_LF)
            hc = 1'b1;
         cs = (pkt[i] == CH_CR);
      end
      hk = hk && ekw;
      hc = hc && ecrlf;
      // A disabled lane leaves the stored state alone
      if (ekw)
      begin
         kw_mem[sid]   = ks;
         kw_saved[sid] = 1'b1;
      end
      if (ecrlf)
      begin
         crlf_mem[sid]   = cs;
         crlf_saved[sid] = 1'b1;
      end
      exp_count_kw    = exp_count_kw + count_t'(hk);
      exp_count_crlf  = exp_count_crlf + count_t'(hc);
      exp_alert_count = exp_alert_count + count_t'(hk && hc);
   endtask

   // Drives pkt as one packet and checks the verdict against the model
   task automatic send_packet(input stream_id_t sid, input bit new_s, input bit ekw,
                              input bit ecrlf);
      bit hk;
      bit hc;
      int waited;
      if (!aborted)
      begin
         model_packet(sid, new_s, ekw, ecrlf, hk, hc);
         @(negedge clk);
         enable_keyword = ekw;
         enable_crlf    = ecrlf;
         load_state     = 1'b1;
         new_stream     = new_s;
         stream_id      = sid;
         foreach (pkt[i])
         begin
            @(negedge clk);
            load_state = 1'b0;
            new_stream = 1'b0;
            byte_in    = pkt[i];
            char_vld   = 1'b1;
         end
         @(negedge clk);
         load_state = 1'b0;
         new_stream = 1'b0;
         char_vld   = 1'b0;
         eop        = 1'b1;
         @(negedge clk);
         eop    = 1'b0;
         waited = 1;
         while (verdict_vld !== 1'b1 && waited < VERDICT_TIMEOUT)
         begin
            @(negedge clk);
            waited++;
         end
         if (verdict_vld !== 1'b1)
         begin
            errors++;
            aborted = 1'b1;
            $display("Timeout: no verdict_vld within %0d cycles after eop on stream %0d",
                     VERDICT_TIMEOUT, sid);
         end
         else
         begin
            if (waited != 2)
            begin
               errors++;
               $display("verdict_vld came %0d cycles after eop instead of 2 on stream %0d",
                        waited, sid);
            end
            check_bit("hit_keyword", hk, hit_keyword);
            check_bit("hit_crlf", hc, hit_crlf);
            check_bit("alert", hk && hc, alert);
            check_count("count_keyword", exp_count_kw, count_keyword);
            check_count("count_crlf", exp_count_crlf, count_crlf);
            check_count("alert_count", exp_alert_count, alert_count);
         end
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before)
         $display("%s: ok", name);
      else
         $display("%s: %0d error(s)", name, errors - errors_before);
   endtask

   task automatic test_single();
      int e0;
      e0 = errors;
      // Counters start from zero after reset
      check_count("count_keyword", '0, count_keyword);
      check_count("count_crlf", '0, count_crlf);
      check_count("alert_count", '0, alert_count);
      load_text("xxGETyy");
      send_packet(1, 1'b1, 1'b1, 1'b1);
      load_text("ab\015\012cd");
      send_packet(2, 1'b1, 1'b1, 1'b1);
      load_text("GET /\015\012");
      send_packet(3, 1'b1, 1'b1, 1'b1);
      // Broken keyword and CR x LF match nothing
      load_text("GEXT\015x\012");
      send_packet(4, 1'b1, 1'b1, 1'b1);
      report_test("single_packet", e0);
   endtask

   task automatic test_carry();
      int e0;
      e0 = errors;
      load_text("abGE");
      send_packet(5, 1'b1, 1'b1, 1'b1);
      load_text("Tz");
      send_packet(5, 1'b0, 1'b1, 1'b1);
      load_text("q\015");
      send_packet(6, 1'b1, 1'b1, 1'b1);
      load_text("\012");
      send_packet(6, 1'b0, 1'b1, 1'b1);
      report_test("cross_packet", e0);
   endtask

   task automatic test_isolation();
      int e0;
      e0 = errors;
      // Halves of each pattern land on different streams
      load_text("y\015");
      send_packet(8, 1'b1, 1'b1, 1'b1);
      load_text("xGE");
      send_packet(7, 1'b1, 1'b1, 1'b1);
      load_text("T\015");
      send_packet(8, 1'b0, 1'b1, 1'b1);
      load_text("\012T");
      send_packet(7, 1'b0, 1'b1, 1'b1);
      // Reopening a stream drops its partial match
      load_text("GE");
      send_packet(9, 1'b1, 1'b1, 1'b1);
      load_text("T");
      send_packet(9, 1'b1, 1'b1, 1'b1);
      report_test("stream_isolation", e0);
   endtask

   task automatic test_disabled();
      int e0;
      e0 = errors;
      load_text("a\015");
      send_packet(10, 1'b1, 1'b1, 1'b1);
      load_text("\012GET\015\012");
      send_packet(10, 1'b0, 1'b1, 1'b0);
      // Stored CR from the first packet is still there
      load_text("\012b");
      send_packet(10, 1'b0, 1'b1, 1'b1);
      report_test("disabled_lane", e0);
   endtask

   function automatic byte_t random_byte();
      case ($unsigned($random(seed)) % 6)
         0: random_byte = CH_G;
         1: random_byte = CH_E;
         2: random_byte = CH_T;
         3: random_byte = CH_CR;
         4: random_byte = CH_LF;
         default: random_byte = "x";
      endcase
   endfunction

   task automatic test_random();
      int         e0;
      int         len;
      stream_id_t sid;
      bit         ekw;
      bit         ecrlf;
      bit         new_s;
      e0 = errors;
      for (int n = 0; n < 40; n++)
      begin
         sid = stream_id_t'(40 + $unsigned($random(seed)) % 8);
         len = 1 + $unsigned($random(seed)) % 12;
         pkt.delete();
         for (int i = 0; i < len; i++)
            pkt.push_back(random_byte());
         ekw   = ($unsigned($random(seed)) % 4) != 0;
         ecrlf = ($unsigned($random(seed)) % 4) != 0;
         // Streams with an unwritten slot are opened fresh
         new_s = !kw_saved[sid] || !crlf_saved[sid] || ($unsigned($random(seed)) % 8 == 0);
         send_packet(sid, new_s, ekw, ecrlf);
      end
      report_test("random_traffic", e0);
   endtask

   initial
   begin
      seed            = 32'h4804_4baa;
      errors          = 0;
      checks          = 0;
      aborted         = 1'b0;
      exp_count_kw    = '0;
      exp_count_crlf  = '0;
      exp_alert_count = '0;
      rst_n           = 1'b0;
      byte_in         = '0;
      char_vld        = 1'b0;
      load_state      = 1'b0;
      new_stream      = 1'b0;
      stream_id       = '0;
      eop             = 1'b0;
      enable_keyword  = 1'b1;
      enable_crlf     = 1'b1;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      test_single();
      test_carry();
      test_isolation();
      test_disabled();
      test_random();
      errors = errors + stream_scan_top_i.chk_i.fail_count;
      $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
               stream_scan_top_i.chk_i.fail_count);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- sources.f
+incdir+common
common/scan_pkg.sv
common/scan_if.sv
matcher/stream_ctx_store.sv
matcher/dfa_keyword.sv
matcher/dfa_crlf.sv
matcher/stream_matcher.sv
verilog/scan_combiner.sv
verilog/stream_scan_top.sv
test/stream_scan_chk.sv
test/stream_scan_tb.sv

//--- run.sh
#!/bin/sh
# Builds the scanner testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sources.f --top-module stream_scan_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vstream_scan_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
